/* src/sh_pkg.sv */
package sh_pkg;

	// ****************************************
	// Widths and constants
	// ****************************************
	localparam int XLEN    = 32;
	localparam int ILEN    = 16;
	localparam int REG_NUM = 16;
	localparam int REG_AW  = 4;

	localparam logic [ILEN-1:0] NOP_INSTR = 16'h0009;
	localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;

	// ****************************************
	// Decoded instruction fields
	// ****************************************
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B,
		ALU_CMPEQ,
		ALU_SHLL,
		ALU_SHLR,
		ALU_MOVT
	} alu_op_t;

	// Store access width
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_WORD,
		SZ_LONG
	} mem_size_t;

	typedef enum logic {
		SRCB_REG,
		SRCB_IMM
	} src_b_t;

endpackage

/* src/sh_regfile.sv */
`timescale 1ns/1ps

module sh_regfile import sh_pkg::*; (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic [REG_AW-1:0] rs_a_num,
	input  logic [REG_AW-1:0] rs_b_num,
	input  logic [REG_AW-1:0] wr_num,
	input  logic [XLEN-1:0]   wr_data,
	input  logic              wr_en,

	output logic [XLEN-1:0]   rs_a_data,
	output logic [XLEN-1:0]   rs_b_data
);

	logic [XLEN-1:0] regs [REG_NUM];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_num] <= wr_data;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rs_a_data = (wr_en && wr_num == rs_a_num) ? wr_data : regs[rs_a_num];
	assign rs_b_data = (wr_en && wr_num == rs_b_num) ? wr_data : regs[rs_b_num];

endmodule

/* src/sh_front_end.sv */
`timescale 1ns/1ps

module sh_front_end import sh_pkg::*; (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              stall,
	input  logic [ILEN-1:0]   ibus_di,

	output logic [XLEN-1:0]   ibus_a,
	output logic [REG_AW-1:0] rs_a_num,
	output logic [REG_AW-1:0] rs_b_num,
	output alu_op_t           ex_op,
	output src_b_t            ex_src_b,
	output logic [XLEN-1:0]   ex_imm,
	output logic [REG_AW-1:0] ex_rd_num,
	output logic              ex_rd_we,
	output logic [REG_AW-1:0] ex_ra_num,
	output logic [REG_AW-1:0] ex_rb_num,
	output logic              ex_store,
	output mem_size_t         ex_size
);

	logic [XLEN-1:0] pc;
	logic [ILEN-1:0] ir;
	logic [ILEN-1:0] ir_hold;
	logic            fetch_on;
	logic            hold_valid;

	alu_op_t         dec_op;
	src_b_t          dec_src_b;
	logic            dec_rd_we;
	logic            dec_store;
	mem_size_t       dec_size;

	// ****************************************
	// Fetch
	// ****************************************
	assign ibus_a = pc;

	// The bus keeps reading at a frozen pc, so park the word it showed
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc         <= RESET_PC;
			ir         <= NOP_INSTR;
			fetch_on   <= 1'b0;
			hold_valid <= 1'b0;
		end else if (stall) begin
			hold_valid <= hold_valid | fetch_on;
		end else begin
			pc         <= pc + XLEN'(2);
			fetch_on   <= 1'b1;
			hold_valid <= 1'b0;
			if (hold_valid) begin
				ir <= ir_hold;
			end else if (fetch_on) begin
				ir <= ibus_di;
			end else begin
				ir <= NOP_INSTR;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (stall && !hold_valid) begin
			ir_hold <= ibus_di;
		end
	end

	// ****************************************
	// Decode
	// ****************************************
	assign rs_a_num = ir[11:8];
	assign rs_b_num = ir[7:4];

	always_comb begin
		dec_op    = ALU_PASS_B;
		dec_src_b = SRCB_REG;
		dec_rd_we = 1'b0;
		dec_store = 1'b0;
		dec_size  = SZ_LONG;
		case (ir[15:12])
			4'h0: begin
				if (ir[7:0] == 8'h29) begin
					dec_op    = ALU_MOVT;
					dec_rd_we = 1'b1;
				end
			end
			4'h2: begin
				case (ir[3:0])
					4'h0: begin
						dec_store = 1'b1;
						dec_size  = SZ_BYTE;
					end
					4'h1: begin
						dec_store = 1'b1;
						dec_size  = SZ_WORD;
					end
					4'h2: dec_store = 1'b1;
					4'h9: begin
						dec_op    = ALU_AND;
						dec_rd_we = 1'b1;
					end
					4'hA: begin
						dec_op    = ALU_XOR;
						dec_rd_we = 1'b1;
					end
					4'hB: begin
						dec_op    = ALU_OR;
						dec_rd_we = 1'b1;
					end
					default: ;
				endcase
			end
			4'h3: begin
				case (ir[3:0])
					4'h0: dec_op = ALU_CMPEQ;
					4'h8: begin
						dec_op    = ALU_SUB;
						dec_rd_we = 1'b1;
					end
					4'hC: begin
						dec_op    = ALU_ADD;
						dec_rd_we = 1'b1;
					end
					default: ;
				endcase
			end
			4'h4: begin
				if (ir[7:1] == 7'h00) begin
					dec_op    = ir[0] ? ALU_SHLR : ALU_SHLL;
					dec_rd_we = 1'b1;
				end
			end
			4'h6: dec_rd_we = (ir[3:0] == 4'h3);
			4'h7: begin
				dec_op    = ALU_ADD;
				dec_src_b = SRCB_IMM;
				dec_rd_we = 1'b1;
			end
			4'hE: begin
				dec_src_b = SRCB_IMM;
				dec_rd_we = 1'b1;
			end
			default: ;
		endcase
	end

	// ****************************************
	// Decode to execute register
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_op    <= ALU_PASS_B;
			ex_rd_we <= 1'b0;
			ex_store <= 1'b0;
		end else if (!stall) begin
			ex_op    <= dec_op;
			ex_rd_we <= dec_rd_we;
			ex_store <= dec_store;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			ex_src_b  <= dec_src_b;
			ex_imm    <= {{(XLEN-8){ir[7]}}, ir[7:0]};
			ex_rd_num <= ir[11:8];
			ex_ra_num <= rs_a_num;
			ex_rb_num <= rs_b_num;
			ex_size   <= dec_size;
		end
	end

endmodule

/* src/sh_execute.sv */
`timescale 1ns/1ps

module sh_execute import sh_pkg::*; (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              stall,

	input  alu_op_t           ex_op,
	input  src_b_t            ex_src_b,
	input  logic [XLEN-1:0]   ex_imm,
	input  logic [REG_AW-1:0] ex_rd_num,
	input  logic              ex_rd_we,
	input  logic [REG_AW-1:0] ex_ra_num,
	input  logic [REG_AW-1:0] ex_rb_num,
	input  logic              ex_store,
	input  mem_size_t         ex_size,
	input  logic [XLEN-1:0]   rs_a_data,
	input  logic [XLEN-1:0]   rs_b_data,

	input  logic [REG_AW-1:0] wb_num,
	input  logic [XLEN-1:0]   wb_data,
	input  logic              wb_en,

	output logic              ma_store,
	output mem_size_t         ma_size,
	output logic [XLEN-1:0]   ma_addr,
	output logic [XLEN-1:0]   ma_wdata,
	output logic [REG_AW-1:0] ma_rd_num,
	output logic              ma_rd_we,
	output logic [XLEN-1:0]   ma_result
);

	logic [XLEN-1:0] op_a_q;
	logic [XLEN-1:0] op_b_q;
	logic [XLEN-1:0] fwd_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic            t_flag;
	logic            t_next;

	// ****************************************
	// Operand bypass
	// ****************************************
	function automatic logic [XLEN-1:0] bypass(
		input logic [REG_AW-1:0] num,
		input logic [XLEN-1:0]   held
	);
		if (ma_rd_we && ma_rd_num == num) begin
			return ma_result;
		end else if (wb_en && wb_num == num) begin
			return wb_data;
		end
		return held;
	endfunction

	always_comb begin
		fwd_a = bypass(ex_ra_num, op_a_q);
		fwd_b = bypass(ex_rb_num, op_b_q);
		op_b  = (ex_src_b == SRCB_IMM) ? ex_imm : fwd_b;
	end

	// Refreshed while frozen, the WB result is gone after the stall
	always_ff @(posedge CLK) begin
		op_a_q <= stall ? fwd_a : rs_a_data;
		op_b_q <= stall ? fwd_b : rs_b_data;
	end

	// ****************************************
	// ALU and T flag
	// ****************************************
	always_comb begin
		alu_res = op_b;
		t_next  = t_flag;
		case (ex_op)
			ALU_ADD:    alu_res = fwd_a + op_b;
			ALU_SUB:    alu_res = fwd_a - op_b;
			ALU_AND:    alu_res = fwd_a & op_b;
			ALU_OR:     alu_res = fwd_a | op_b;
			ALU_XOR:    alu_res = fwd_a ^ op_b;
			ALU_PASS_B: alu_res = op_b;
			ALU_CMPEQ:  t_next = (fwd_a == op_b);
			ALU_SHLL: begin
				alu_res = {fwd_a[XLEN-2:0], 1'b0};
				t_next  = fwd_a[XLEN-1];
			end
			ALU_SHLR: begin
				alu_res = {1'b0, fwd_a[XLEN-1:1]};
				t_next  = fwd_a[0];
			end
			ALU_MOVT:   alu_res = {{(XLEN-1){1'b0}}, t_flag};
			default: ;
		endcase
	end

	// ****************************************
	// Execute to memory register
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t_flag   <= 1'b0;
			ma_store <= 1'b0;
			ma_rd_we <= 1'b0;
		end else if (!stall) begin
			t_flag   <= t_next;
			ma_store <= ex_store;
			ma_rd_we <= ex_rd_we;
		end
	end

	// Store address from Rn, data from Rm
	always_ff @(posedge CLK) begin
		if (!stall) begin
			ma_size   <= ex_size;
			ma_addr   <= fwd_a;
			ma_wdata  <= fwd_b;
			ma_rd_num <= ex_rd_num;
			ma_result <= alu_res;
		end
	end

endmodule

/* src/sh_mem_access.sv */
`timescale 1ns/1ps

module sh_mem_access import sh_pkg::*; (
	input  logic              CLK,
	input  logic              RST_N,

	input  logic              ma_store,
	input  mem_size_t         ma_size,
	input  logic [XLEN-1:0]   ma_addr,
	input  logic [XLEN-1:0]   ma_wdata,
	input  logic [REG_AW-1:0] ma_rd_num,
	input  logic              ma_rd_we,
	input  logic [XLEN-1:0]   ma_result,
	input  logic              BUS_WAIT,

	output logic              stall,
	output logic [XLEN-1:0]   BUS_A,
	output logic [XLEN-1:0]   BUS_DO,
	output logic [3:0]        BUS_BA,
	output logic              BUS_WR,
	output logic [REG_AW-1:0] wb_num,
	output logic [XLEN-1:0]   wb_data,
	output logic              wb_en
);

	// Whole pipeline holds while a store waits on the bus
	assign stall  = ma_store & BUS_WAIT;

	assign BUS_WR = ma_store;
	assign BUS_A  = ma_addr;

	// ****************************************
	// Big-endian lanes
	// ****************************************
	always_comb begin
		case (ma_size)
			SZ_BYTE: begin
				BUS_DO = {4{ma_wdata[7:0]}};
				BUS_BA = 4'b1000 >> ma_addr[1:0];
			end
			SZ_WORD: begin
				BUS_DO = {2{ma_wdata[15:0]}};
				BUS_BA = ma_addr[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				BUS_DO = ma_wdata;
				BUS_BA = 4'b1111;
			end
		endcase
	end

	// ****************************************
	// Write-back register
	// ****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= ma_rd_we & ~stall;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			wb_num  <= ma_rd_num;
			wb_data <= ma_result;
		end
	end

endmodule

/* src/sh_core.sv */
`timescale 1ns/1ps

module sh_core import sh_pkg::*; (
	input  logic            CLK,
	input  logic            RST_N,

	output logic [XLEN-1:0] IBUS_A,
	input  logic [ILEN-1:0] IBUS_DI,

	output logic [XLEN-1:0] BUS_A,
	output logic [XLEN-1:0] BUS_DO,
	output logic [3:0]      BUS_BA,
	output logic            BUS_WR,
	input  logic            BUS_WAIT
);

	logic              stall;

	// Register file read port
	logic [REG_AW-1:0] rs_a_num;
	logic [REG_AW-1:0] rs_b_num;
	logic [XLEN-1:0]   rs_a_data;
	logic [XLEN-1:0]   rs_b_data;

	// Decode to execute
	alu_op_t           ex_op;
	src_b_t            ex_src_b;
	logic [XLEN-1:0]   ex_imm;
	logic [REG_AW-1:0] ex_rd_num;
	logic              ex_rd_we;
	logic [REG_AW-1:0] ex_ra_num;
	logic [REG_AW-1:0] ex_rb_num;
	logic              ex_store;
	mem_size_t         ex_size;

	// Execute to memory access
	logic              ma_store;
	mem_size_t         ma_size;
	logic [XLEN-1:0]   ma_addr;
	logic [XLEN-1:0]   ma_wdata;
	logic [REG_AW-1:0] ma_rd_num;
	logic              ma_rd_we;
	logic [XLEN-1:0]   ma_result;

	// Write-back
	logic [REG_AW-1:0] wb_num;
	logic [XLEN-1:0]   wb_data;
	logic              wb_en;

	sh_front_end front_end_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.stall     (stall),
		.ibus_di   (IBUS_DI),
		.ibus_a    (IBUS_A),
		.rs_a_num  (rs_a_num),
		.rs_b_num  (rs_b_num),
		.ex_op     (ex_op),
		.ex_src_b  (ex_src_b),
		.ex_imm    (ex_imm),
		.ex_rd_num (ex_rd_num),
		.ex_rd_we  (ex_rd_we),
		.ex_ra_num (ex_ra_num),
		.ex_rb_num (ex_rb_num),
		.ex_store  (ex_store),
		.ex_size   (ex_size)
	);

	sh_regfile regfile_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.rs_a_num  (rs_a_num),
		.rs_b_num  (rs_b_num),
		.wr_num    (wb_num),
		.wr_data   (wb_data),
		.wr_en     (wb_en),
		.rs_a_data (rs_a_data),
		.rs_b_data (rs_b_data)
	);

	sh_execute execute_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.stall     (stall),
		.ex_op     (ex_op),
		.ex_src_b  (ex_src_b),
		.ex_imm    (ex_imm),
		.ex_rd_num (ex_rd_num),
		.ex_rd_we  (ex_rd_we),
		.ex_ra_num (ex_ra_num),
		.ex_rb_num (ex_rb_num),
		.ex_store  (ex_store),
		.ex_size   (ex_size),
		.rs_a_data (rs_a_data),
		.rs_b_data (rs_b_data),
		.wb_num    (wb_num),
		.wb_data   (wb_data),
		.wb_en     (wb_en),
		.ma_store  (ma_store),
		.ma_size   (ma_size),
		.ma_addr   (ma_addr),
		.ma_wdata  (ma_wdata),
		.ma_rd_num (ma_rd_num),
		.ma_rd_we  (ma_rd_we),
		.ma_result (ma_result)
	);

	sh_mem_access mem_access_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ma_store  (ma_store),
		.ma_size   (ma_size),
		.ma_addr   (ma_addr),
		.ma_wdata  (ma_wdata),
		.ma_rd_num (ma_rd_num),
		.ma_rd_we  (ma_rd_we),
		.ma_result (ma_result),
		.BUS_WAIT  (BUS_WAIT),
		.stall     (stall),
		.BUS_A     (BUS_A),
		.BUS_DO    (BUS_DO),
		.BUS_BA    (BUS_BA),
		.BUS_WR    (BUS_WR),
		.wb_num    (wb_num),
		.wb_data   (wb_data),
		.wb_en     (wb_en)
	);

endmodule

/* sim/sh_checker.sv */
`timescale 1ns/1ps

module sh_checker import sh_pkg::*; (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic [XLEN-1:0] bus_a,
	input  logic [XLEN-1:0] bus_do,
	input  logic [3:0]      bus_ba,
	input  logic            bus_wr,
	input  logic            bus_wait,
	output int              seen,
	output int              passed,
	output int              errors
);

	logic [XLEN-1:0] want_a_q [$];
	logic [XLEN-1:0] want_do_q [$];
	logic [3:0]      want_ba_q [$];
	logic [XLEN-1:0] want_a;
	logic [XLEN-1:0] want_do;
	logic [3:0]      want_ba;
	logic            bad;

	task automatic expect_store(
		input logic [XLEN-1:0] addr,
		input logic [XLEN-1:0] data,
		input logic [3:0]      lanes
	);
		want_a_q.push_back(addr);
		want_do_q.push_back(data);
		want_ba_q.push_back(lanes);
	endtask

	function automatic int stores_left();
		return want_a_q.size();
	endfunction

	// ****************************************
	// Store completes with BUS_WR high, BUS_WAIT low
	// ****************************************
	always @(posedge CLK) begin
		if (!RST_N) begin
			seen   <= 0;
			passed <= 0;
			errors <= 0;
		end else if (bus_wr && !bus_wait) begin
			seen <= seen + 1;
			if (want_a_q.size() == 0) begin
				$display("Store %0d to address %h came after all expected stores", seen, bus_a);
				errors <= errors + 1;
			end else begin
				want_a  = want_a_q.pop_front();
				want_do = want_do_q.pop_front();
				want_ba = want_ba_q.pop_front();
				bad     = 1'b0;
				if (bus_a !== want_a) begin
					$display("FAILED store %0d: BUS_A expected %h, got %h", seen, want_a, bus_a);
					bad = 1'b1;
				end
				if (bus_do !== want_do) begin
					$display("FAILED store %0d: BUS_DO expected %h, got %h", seen, want_do, bus_do);
					bad = 1'b1;
				end
				if (bus_ba !== want_ba) begin
					$display("FAILED store %0d: BUS_BA expected %h, got %h", seen, want_ba, bus_ba);
					bad = 1'b1;
				end
				if (bad) begin
					errors <= errors + 1;
				end else begin
					$display("PASS store %0d: BUS_A %h BUS_DO %h BUS_BA %h",
						seen, bus_a, bus_do, bus_ba);
					passed <= passed + 1;
				end
			end
		end
	end

endmodule

/* sim/tb_sh_core.sv */
`timescale 1ns/1ps

module tb_sh_core import sh_pkg::*; ();

	localparam int PROG_N = 75;
	localparam int EXP_N  = 24;
	localparam int IMEM_N = 128;
	localparam int LIMIT  = 4 * (PROG_N + 10);
	// Fetch address at which the last program store has left MA
	localparam logic [XLEN-1:0] DONE_PC = XLEN'(2 * (PROG_N + 8));

	logic            CLK;
	logic            RST_N;
	logic [XLEN-1:0] ibus_a;
	logic [ILEN-1:0] ibus_di = NOP_INSTR;
	logic [XLEN-1:0] bus_a;
	logic [XLEN-1:0] bus_do;
	logic [3:0]      bus_ba;
	logic            bus_wr;
	logic            bus_wait = 1'b0;

	logic [ILEN-1:0] imem [IMEM_N];
	int              seed = 32'h7d10_e593;
	int              cycles;
	int              seen;
	int              passed;
	int              errors;

	// ****************************************
	// Program and expected stores
	// ****************************************
	logic [ILEN-1:0] prog [PROG_N] = '{
		// MOV #imm, MOV.L
		16'hE1FD, 16'hE240, 16'h2212, 16'hE37F, 16'h7204, 16'h2232, 16'hE380, 16'h2232,
		// Bypass distances one to three
		16'hE405, 16'h344C, 16'h7403, 16'hE501, 16'h354C, 16'h0009, 16'h0009, 16'h354C,
		16'h7204, 16'h2252, 16'h2242, 16'h7501, 16'h0009, 16'h0009, 16'h2252,
		// SUB AND OR XOR MOV, then an unknown encoding
		16'hE65A, 16'hE733, 16'h6863, 16'h3878, 16'h7204, 16'h2282, 16'h6963, 16'h2979,
		16'h2292, 16'h6A63, 16'h2A7B, 16'h22A2, 16'h6B63, 16'h2B7A, 16'h22B2, 16'h3768,
		16'h2272, 16'h2678,
		// T flag from CMP/EQ, SHLL, SHLR
		16'hEC5A, 16'h7204, 16'h3C60, 16'h0D29, 16'h22D2, 16'h3C70, 16'h0D29, 16'h22D2,
		16'hEE80, 16'h4E00, 16'h0D29, 16'h22D2, 16'h4E01, 16'h0D29, 16'h22D2, 16'h22E2,
		16'hEF01, 16'h4F01, 16'h0D29, 16'h22D2, 16'h22F2,
		// Byte and word lanes
		16'hE020, 16'hE1A5, 16'h2010, 16'h7001, 16'h2010, 16'h7001, 16'h2010, 16'h7001,
		16'h2010, 16'h7001, 16'h2011, 16'h7002, 16'h2011
	};

	// Address, data, lanes
	logic [67:0] exp_tab [EXP_N] = '{
		{32'h0000_0040, 32'hFFFF_FFFD, 4'hF},
		{32'h0000_0044, 32'h0000_007F, 4'hF},
		{32'h0000_0044, 32'hFFFF_FF80, 4'hF},
		{32'h0000_0048, 32'h0000_001B, 4'hF},
		{32'h0000_0048, 32'h0000_000D, 4'hF},
		{32'h0000_0048, 32'h0000_001C, 4'hF},
		{32'h0000_004C, 32'h0000_0027, 4'hF},
		{32'h0000_004C, 32'h0000_0012, 4'hF},
		{32'h0000_004C, 32'h0000_007B, 4'hF},
		{32'h0000_004C, 32'h0000_0069, 4'hF},
		{32'h0000_004C, 32'hFFFF_FFD9, 4'hF},
		{32'h0000_0050, 32'h0000_0001, 4'hF},
		{32'h0000_0050, 32'h0000_0000, 4'hF},
		{32'h0000_0050, 32'h0000_0001, 4'hF},
		{32'h0000_0050, 32'h0000_0000, 4'hF},
		{32'h0000_0050, 32'h7FFF_FF80, 4'hF},
		{32'h0000_0050, 32'h0000_0001, 4'hF},
		{32'h0000_0050, 32'h0000_0000, 4'hF},
		{32'h0000_0020, 32'hA5A5_A5A5, 4'h8},
		{32'h0000_0021, 32'hA5A5_A5A5, 4'h4},
		{32'h0000_0022, 32'hA5A5_A5A5, 4'h2},
		{32'h0000_0023, 32'hA5A5_A5A5, 4'h1},
		{32'h0000_0024, 32'hFFA5_FFA5, 4'hC},
		{32'h0000_0026, 32'hFFA5_FFA5, 4'h3}
	};

	sh_core dut_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.IBUS_A   (ibus_a),
		.IBUS_DI  (ibus_di),
		.BUS_A    (bus_a),
		.BUS_DO   (bus_do),
		.BUS_BA   (bus_ba),
		.BUS_WR   (bus_wr),
		.BUS_WAIT (bus_wait)
	);

	sh_checker checker_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.bus_a    (bus_a),
		.bus_do   (bus_do),
		.bus_ba   (bus_ba),
		.bus_wr   (bus_wr),
		.bus_wait (bus_wait),
		.seen     (seen),
		.passed   (passed),
		.errors   (errors)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Instruction memory with one cycle of read latency
	always @(posedge CLK) begin
		if (ibus_a < XLEN'(2 * IMEM_N)) begin
			ibus_di <= imem[ibus_a[7:1]];
		end else begin
			ibus_di <= NOP_INSTR;
		end
	end

	// Wait high about one cycle in three
	always @(posedge CLK) begin
		bus_wait <= ($random(seed) % 3) == 0;
	end

	initial begin
		RST_N  = 1'b0;
		cycles = 0;
		for (int i = 0; i < IMEM_N; i++) begin
			imem[i] = NOP_INSTR;
		end
		for (int i = 0; i < PROG_N; i++) begin
			imem[i] = prog[i];
		end
		for (int i = 0; i < EXP_N; i++) begin
			checker_i.expect_store(exp_tab[i][67:36], exp_tab[i][35:4], exp_tab[i][3:0]);
		end
		repeat (10) @(posedge CLK);
		RST_N <= 1'b1;

		while (ibus_a < DONE_PC && cycles < LIMIT) begin
			@(posedge CLK);
			cycles++;
		end
		@(negedge CLK);

		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles with %0d expected stores still missing",
				cycles, checker_i.stores_left());
		end else if (checker_i.stores_left() != 0) begin
			$display("Program ended with %0d expected stores never seen on the bus",
				checker_i.stores_left());
		end
		$display("Stores seen %0d of %0d, passed %0d, errors %0d", seen, EXP_N, passed, errors);
		if (cycles < LIMIT && passed == EXP_N && errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
src/sh_pkg.sv
src/sh_regfile.sv
src/sh_front_end.sv
src/sh_execute.sv
src/sh_mem_access.sv
src/sh_core.sv
sim/sh_checker.sv
sim/tb_sh_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_sh_core -Mdir obj_dir -o sim_tb_sh_core
./obj_dir/sim_tb_sh_core | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
